// File: rtl/csr_pkg.sv
package csr_pkg;

    localparam int XLEN = 64;

    // machine CSR addresses.
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // SXL and UXL fixed at 64 bits, MPP at machine mode.
    localparam logic [XLEN-1:0] MSTATUS_RST = 64'h0000_000a_0000_1800;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    localparam logic [3:0] IRQ_SW    = 4'd3;
    localparam logic [3:0] IRQ_TIMER = 4'd7;
    localparam logic [3:0] IRQ_EXT   = 4'd11;

    // encodings follow the low two bits of funct3 for csrrw, csrrs and csrrc.
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic            valid;
        csr_op_e         op;
        logic [11:0]     addr;
        logic [XLEN-1:0] operand;
    } csr_cmd_t;

    typedef struct packed {
        logic            en;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic            take;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] epc;
    } trap_evt_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [11:0]     paddr;
        logic [XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    // true for the five implemented registers.
    function automatic logic csr_is_mapped(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// File: rtl/csr_file.sv
`timescale 1ns/100ps
module csr_file import csr_pkg::*; (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  trap_evt_t       trap,
    input  logic            mret_do,
    input  csr_wr_t         core_wr,
    input  csr_wr_t         apb_wr,
    input  logic [11:0]     core_raddr,
    input  logic [11:0]     apb_raddr,
    output logic [XLEN-1:0] core_rdata,
    output logic [XLEN-1:0] apb_rdata,
    output logic            apb_raddr_ok,
    output logic            apb_wr_ok,
    output logic [XLEN-1:0] mstatus,
    output logic [XLEN-1:0] mtvec,
    output logic [XLEN-1:0] mepc
);

    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mscratch;
    csr_wr_t         sel_wr;

    // the debug port only gets the cycle when nothing on the core side writes.
    assign apb_wr_ok = ~(trap.take | mret_do | core_wr.en);
    assign sel_wr    = core_wr.en ? core_wr : apb_wr;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus  <= MSTATUS_RST;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (trap.take) begin
            mepc              <= trap.epc;
            mcause            <= trap.cause;
            mstatus[MPIE_BIT] <= mstatus[MIE_BIT];
            mstatus[MIE_BIT]  <= 1'b0;  // interrupts stay off inside the handler.
        end else if (mret_do) begin
            mstatus[MIE_BIT]  <= mstatus[MPIE_BIT];
            mstatus[MPIE_BIT] <= 1'b1;
        end else if (sel_wr.en) begin
            case (sel_wr.addr)
                CSR_MSTATUS:  mstatus  <= sel_wr.data;
                CSR_MTVEC:    mtvec    <= sel_wr.data;
                CSR_MEPC:     mepc     <= sel_wr.data;
                CSR_MCAUSE:   mcause   <= sel_wr.data;
                CSR_MSCRATCH: mscratch <= sel_wr.data;
                default: ;
            endcase
        end
    end

    function automatic logic [XLEN-1:0] read_csr(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  return mstatus;
            CSR_MTVEC:    return mtvec;
            CSR_MEPC:     return mepc;
            CSR_MCAUSE:   return mcause;
            CSR_MSCRATCH: return mscratch;
            default:      return '0;
        endcase
    endfunction

    always_comb begin
        core_rdata = read_csr(core_raddr);
        apb_rdata  = read_csr(apb_raddr);
    end

    assign apb_raddr_ok = csr_is_mapped(apb_raddr);

endmodule

// File: rtl/csr_op_unit.sv
`timescale 1ns/100ps
module csr_op_unit import csr_pkg::*; (
    input  csr_cmd_t        cmd,
    input  logic [XLEN-1:0] old_value,
    output logic [11:0]     raddr,
    output logic [XLEN-1:0] rdata,
    output logic            illegal,
    output csr_wr_t         wr
);

    logic [XLEN-1:0] new_value;
    logic            wants_wr;
    logic            mapped;

    assign raddr  = cmd.addr;
    assign rdata  = old_value;    // the instruction always returns the old value.
    assign mapped = csr_is_mapped(cmd.addr);

    always_comb begin
        new_value = old_value;
        wants_wr  = 1'b0;
        case (cmd.op)
            CSR_RW: begin
                new_value = cmd.operand;
                wants_wr  = 1'b1;
            end
            CSR_RS: begin
                new_value = old_value | cmd.operand;
                wants_wr  = |cmd.operand;  // a zero mask is a pure read.
            end
            CSR_RC: begin
                new_value = old_value & ~cmd.operand;
                wants_wr  = |cmd.operand;
            end
            default: ;
        endcase
    end

    assign illegal = cmd.valid & ~mapped;

    always_comb begin
        wr.en   = cmd.valid & mapped & wants_wr;
        wr.addr = cmd.addr;
        wr.data = new_value;
    end

endmodule

// File: rtl/trap_ctrl.sv
`timescale 1ns/100ps
module trap_ctrl import csr_pkg::*; (
    input  logic [2:0]      irq,      // bit 0 software, bit 1 timer, bit 2 external.
    input  logic [XLEN-1:0] pc,
    input  logic            mret,
    input  logic [XLEN-1:0] mstatus,
    input  logic [XLEN-1:0] mtvec,
    input  logic [XLEN-1:0] mepc,
    output trap_evt_t       trap,
    output logic            mret_do,
    output redirect_t       redirect
);

    logic       take;
    logic [3:0] code;

    assign take = mstatus[MIE_BIT] & (|irq);

    // external wins, then software, then timer.
    always_comb begin
        if (irq[2]) begin
            code = IRQ_EXT;
        end else if (irq[0]) begin
            code = IRQ_SW;
        end else begin
            code = IRQ_TIMER;
        end
    end

    always_comb begin
        trap.take  = take;
        trap.cause = {1'b1, {(XLEN-5){1'b0}}, code};  // interrupt flag in bit 63.
        trap.epc   = pc;
    end

    assign mret_do = mret & ~take;

    // direct mode only, so the low two bits of mtvec are dropped.
    always_comb begin
        redirect.valid = take | mret_do;
        if (take) begin
            redirect.pc = {mtvec[XLEN-1:2], 2'b00};
        end else if (mret_do) begin
            redirect.pc = mepc;
        end else begin
            redirect.pc = '0;
        end
    end

endmodule

// File: rtl/apb_csr_port.sv
`timescale 1ns/100ps
module apb_csr_port import csr_pkg::*; (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  apb_req_t        req,
    output apb_rsp_t        rsp,
    output logic [11:0]     raddr,
    input  logic [XLEN-1:0] rdata,
    input  logic            raddr_ok,
    input  logic            wr_ok,
    output csr_wr_t         wr
);

    logic setup_seen;
    logic access;
    logic ready;

    // an access phase only counts once its setup phase has been seen.
    assign access = req.psel & req.penable & setup_seen;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            setup_seen <= 1'b0;
        end else if (req.psel & ~req.penable) begin
            setup_seen <= 1'b1;
        end else if (ready) begin
            setup_seen <= 1'b0;  // the next transfer starts with a new setup.
        end
    end

    assign raddr = req.paddr;

    // reads and unmapped accesses finish at once; a mapped write waits for the file.
    assign ready = access & (~req.pwrite | ~raddr_ok | wr_ok);

    always_comb begin
        wr.en   = access & req.pwrite & raddr_ok;
        wr.addr = req.paddr;
        wr.data = req.pwdata;
    end

    always_comb begin
        rsp.pready  = ready;
        rsp.pslverr = access & ~raddr_ok;
        rsp.prdata  = (access & ~req.pwrite) ? rdata : '0;
    end

endmodule

// File: rtl/csr_unit_top.sv
`timescale 1ns/100ps
module csr_unit_top import csr_pkg::*; (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  csr_cmd_t        core_cmd,
    output logic [XLEN-1:0] core_rdata,
    output logic            core_illegal,
    input  logic [2:0]      irq,
    input  logic [XLEN-1:0] pc,
    input  logic            mret,
    output redirect_t       redirect,
    input  apb_req_t        apb_req,
    output apb_rsp_t        apb_rsp
);

    trap_evt_t       trap;
    logic            mret_do;
    csr_wr_t         core_wr;
    csr_wr_t         apb_wr;
    logic [11:0]     core_raddr;
    logic [11:0]     apb_raddr;
    logic [XLEN-1:0] core_old;
    logic [XLEN-1:0] apb_rdata;
    logic            apb_raddr_ok;
    logic            apb_wr_ok;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    csr_file u_csr_file (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .trap         (trap),
        .mret_do      (mret_do),
        .core_wr      (core_wr),
        .apb_wr       (apb_wr),
        .core_raddr   (core_raddr),
        .apb_raddr    (apb_raddr),
        .core_rdata   (core_old),
        .apb_rdata    (apb_rdata),
        .apb_raddr_ok (apb_raddr_ok),
        .apb_wr_ok    (apb_wr_ok),
        .mstatus      (mstatus),
        .mtvec        (mtvec),
        .mepc         (mepc)
    );

    csr_op_unit u_csr_op_unit (
        .cmd       (core_cmd),
        .old_value (core_old),
        .raddr     (core_raddr),
        .rdata     (core_rdata),
        .illegal   (core_illegal),
        .wr        (core_wr)
    );

    trap_ctrl u_trap_ctrl (
        .irq      (irq),
        .pc       (pc),
        .mret     (mret),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .trap     (trap),
        .mret_do  (mret_do),
        .redirect (redirect)
    );

    apb_csr_port u_apb_csr_port (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .req       (apb_req),
        .rsp       (apb_rsp),
        .raddr     (apb_raddr),
        .rdata     (apb_rdata),
        .raddr_ok  (apb_raddr_ok),
        .wr_ok     (apb_wr_ok),
        .wr        (apb_wr)
    );

endmodule

// File: bench/csr_unit_assert.sv
`timescale 1ns/100ps
module csr_unit_assert import csr_pkg::*; (
    input logic      I_sys_clk,
    input logic      I_rst,
    input apb_req_t  apb_req,
    input apb_rsp_t  apb_rsp,
    input trap_evt_t trap,
    input logic      mret_do,
    input redirect_t redirect
);

    int failures = 0;

    pready_in_access: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else begin
            failures++;
            $error("pready is high outside an APB access phase.");
        end

    trap_or_mret: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        !(trap.take && mret_do))
        else begin
            failures++;
            $error("trap entry and mret are active in the same cycle.");
        end

    // a redirect happens exactly when a trap or an mret is taken.
    redirect_match: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        redirect.valid == (trap.take || mret_do))
        else begin
            failures++;
            $error("redirect.valid does not follow trap entry or mret.");
        end

endmodule

bind csr_unit_top csr_unit_assert u_assert (
    .I_sys_clk (I_sys_clk),
    .I_rst     (I_rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .trap      (trap),
    .mret_do   (mret_do),
    .redirect  (redirect)
);

// File: bench/tb_csr_unit.sv
`timescale 1ns/100ps
module tb_csr_unit import csr_pkg::*; ();

    localparam int RST_CYCLES  = 16;
    localparam int N_CORE_OPS  = 30;
    localparam int N_IRQ_CASES = 7;
    localparam int N_RACES     = 3;
    localparam logic [11:0] UNMAPPED = 12'h344;

    // an APB transfer takes 3 cycles, a core command 2, an interrupt case 18.
    localparam int TEST_CYCLES = RST_CYCLES + 6 * 3 + 5 * 8 + 6 + N_CORE_OPS * 4 + 2
                               + 9 + N_IRQ_CASES * 18 + 12 + N_RACES * 7 + 2;
    localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 5;

    // model index of each register.
    localparam int IDX_MSTATUS  = 0;
    localparam int IDX_MEPC     = 1;
    localparam int IDX_MTVEC    = 2;
    localparam int IDX_MCAUSE   = 3;
    localparam int IDX_MSCRATCH = 4;

    logic            I_sys_clk;
    logic            I_rst;
    csr_cmd_t        core_cmd;
    logic [XLEN-1:0] core_rdata;
    logic            core_illegal;
    logic [2:0]      irq;
    logic [XLEN-1:0] pc;
    logic            mret;
    redirect_t       redirect;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;

    logic [XLEN-1:0] model [5];
    int seed = 32'h34c3_884f;
    int n_checks = 0;
    int n_errors = 0;
    int apb_waits = 0;
    int cycles = 0;

    csr_unit_top dut0 (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .core_cmd     (core_cmd),
        .core_rdata   (core_rdata),
        .core_illegal (core_illegal),
        .irq          (irq),
        .pc           (pc),
        .mret         (mret),
        .redirect     (redirect),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp)
    );

    initial begin
        I_sys_clk = 1'b0;
        forever #50 I_sys_clk = ~I_sys_clk;
    end

    function automatic int csr_index(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  return IDX_MSTATUS;
            CSR_MEPC:     return IDX_MEPC;
            CSR_MTVEC:    return IDX_MTVEC;
            CSR_MCAUSE:   return IDX_MCAUSE;
            CSR_MSCRATCH: return IDX_MSCRATCH;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [11:0] csr_addr(input int i);
        case (i)
            0:       return CSR_MSTATUS;
            1:       return CSR_MEPC;
            2:       return CSR_MTVEC;
            3:       return CSR_MCAUSE;
            default: return CSR_MSCRATCH;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [11:0] addr);
        int idx;
        idx = csr_index(addr);
        if (idx < 0) return '0;
        return model[idx];
    endfunction

    function automatic logic [XLEN-1:0] ref_csr_op(input csr_op_e op, input logic [XLEN-1:0] old,
                                                   input logic [XLEN-1:0] operand);
        case (op)
            CSR_RS:  return old | operand;
            CSR_RC:  return old & ~operand;
            default: return operand;
        endcase
    endfunction

    // set and clear with an empty mask only read.
    function automatic logic ref_writes(input csr_op_e op, input logic [XLEN-1:0] operand);
        return (op == CSR_RW) || (operand != '0);
    endfunction

    function automatic logic [XLEN-1:0] ref_irq_cause(input logic [2:0] lines);
        logic [XLEN-1:0] cause;
        cause = {1'b1, {(XLEN-1){1'b0}}};
        if (lines[2]) cause[3:0] = IRQ_EXT;
        else if (lines[0]) cause[3:0] = IRQ_SW;
        else cause[3:0] = IRQ_TIMER;
        return cause;
    endfunction

    function automatic logic [XLEN-1:0] ref_trap_status(input logic [XLEN-1:0] ms);
        ms[MPIE_BIT] = ms[MIE_BIT];
        ms[MIE_BIT]  = 1'b0;
        return ms;
    endfunction

    function automatic logic [XLEN-1:0] ref_mret_status(input logic [XLEN-1:0] ms);
        ms[MIE_BIT]  = ms[MPIE_BIT];
        ms[MPIE_BIT] = 1'b1;
        return ms;
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check(input string what, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // expected outputs come from the model before the edge, then the model steps.
    task automatic check_cycle();
        logic            take;
        logic            mret_ok;
        logic            core_wr;
        logic            apb_acc;
        logic            apb_ready;
        logic [XLEN-1:0] exp_pc;
        int              cidx;
        int              aidx;
        take    = model[IDX_MSTATUS][MIE_BIT] & (|irq);
        mret_ok = mret & ~take;
        exp_pc  = take ? {model[IDX_MTVEC][XLEN-1:2], 2'b00} : model[IDX_MEPC];
        check("redirect.valid", redirect.valid, take | mret_ok);
        if (take | mret_ok) check("redirect.pc", redirect.pc, exp_pc);
        cidx    = csr_index(core_cmd.addr);
        core_wr = core_cmd.valid && (cidx >= 0) && ref_writes(core_cmd.op, core_cmd.operand);
        if (core_cmd.valid) begin
            check("core_rdata", core_rdata, model_read(core_cmd.addr));
            check("core_illegal", core_illegal, cidx < 0);
        end
        apb_acc   = apb_req.psel & apb_req.penable;
        aidx      = csr_index(apb_req.paddr);
        apb_ready = apb_acc & (~apb_req.pwrite | (aidx < 0) | ~(take | mret_ok | core_wr));
        check("pready", apb_rsp.pready, apb_ready);
        check("pslverr", apb_rsp.pslverr, apb_acc & (aidx < 0));
        if (apb_acc & ~apb_req.pwrite) check("prdata", apb_rsp.prdata, model_read(apb_req.paddr));
        if (take) begin
            model[IDX_MSTATUS] = ref_trap_status(model[IDX_MSTATUS]);
            model[IDX_MEPC]    = pc;
            model[IDX_MCAUSE]  = ref_irq_cause(irq);
        end else if (mret_ok) begin
            model[IDX_MSTATUS] = ref_mret_status(model[IDX_MSTATUS]);
        end else if (core_wr) begin
            model[cidx] = ref_csr_op(core_cmd.op, model[cidx], core_cmd.operand);
        end else if (apb_ready & apb_req.pwrite & (aidx >= 0)) begin
            model[aidx] = apb_req.pwdata;
        end
    endtask

    always @(negedge I_sys_clk) begin
        if (I_rst) begin
            model[IDX_MSTATUS]  = MSTATUS_RST;
            model[IDX_MEPC]     = '0;
            model[IDX_MTVEC]    = '0;
            model[IDX_MCAUSE]   = '0;
            model[IDX_MSCRATCH] = '0;
        end else begin
            check_cycle();
        end
    end

    always @(posedge I_sys_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic apb_xfer(input logic write, input logic [11:0] addr,
                            input logic [XLEN-1:0] data);
        logic done;
        @(posedge I_sys_clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge I_sys_clk);
        apb_req.penable <= 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge I_sys_clk);
            done = apb_rsp.pready;  // sampled mid-cycle, acted on at the edge.
            if (!done) apb_waits++;
            @(posedge I_sys_clk);
        end
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic core_op(input csr_op_e op, input logic [11:0] addr,
                           input logic [XLEN-1:0] operand);
        @(posedge I_sys_clk);
        core_cmd.valid   <= 1'b1;
        core_cmd.op      <= op;
        core_cmd.addr    <= addr;
        core_cmd.operand <= operand;
        @(posedge I_sys_clk);
        core_cmd.valid <= 1'b0;
    endtask

    task automatic pulse_irq(input logic [2:0] lines, input logic [XLEN-1:0] at_pc);
        @(posedge I_sys_clk);
        irq <= lines;
        pc  <= at_pc;
        @(posedge I_sys_clk);
        irq <= 3'b000;
    endtask

    task automatic issue_mret();
        @(posedge I_sys_clk);
        mret <= 1'b1;
        @(posedge I_sys_clk);
        mret <= 1'b0;
    endtask

    initial begin : stimulus
        logic [XLEN-1:0] data;
        logic [11:0]     addr;
        csr_op_e         op;
        int              sel;
        I_rst    = 1'b1;
        core_cmd = '0;
        irq      = 3'b000;
        pc       = '0;
        mret     = 1'b0;
        apb_req  = '0;
        repeat (RST_CYCLES) @(posedge I_sys_clk);
        I_rst <= 1'b0;

        for (int i = 0; i < 5; i++) apb_xfer(1'b0, csr_addr(i), '0);
        apb_xfer(1'b0, UNMAPPED, '0);

        for (int i = 0; i < 5; i++) begin
            apb_xfer(1'b1, csr_addr(i), rand64());
            apb_xfer(1'b0, csr_addr(i), '0);
            core_op(CSR_RS, csr_addr(i), '0);
        end
        apb_xfer(1'b1, UNMAPPED, rand64());
        apb_xfer(1'b0, UNMAPPED, '0);

        repeat (N_CORE_OPS) begin
            sel  = {$random(seed)} % 3;
            op   = (sel == 0) ? CSR_RW : (sel == 1) ? CSR_RS : CSR_RC;
            addr = csr_addr({$random(seed)} % 5);
            data = ({$random(seed)} % 4 == 0) ? '0 : rand64();
            core_op(op, addr, data);
            core_op(CSR_RS, addr, '0);
        end
        core_op(CSR_RW, UNMAPPED, rand64());

        // interrupts are masked while MIE is clear.
        core_op(CSR_RC, CSR_MSTATUS, 64'h8);
        apb_xfer(1'b1, CSR_MTVEC, rand64());
        pulse_irq(3'b111, rand64());

        for (int v = 1; v <= N_IRQ_CASES; v++) begin
            core_op(CSR_RS, CSR_MSTATUS, 64'h8);
            pulse_irq(v[2:0], rand64());
            apb_xfer(1'b0, CSR_MEPC, '0);
            apb_xfer(1'b0, CSR_MCAUSE, '0);
            apb_xfer(1'b0, CSR_MSTATUS, '0);
            issue_mret();
            apb_xfer(1'b0, CSR_MSTATUS, '0);
        end

        // a trap wins over a core write and an mret in the same cycle.
        fork
            pulse_irq(3'b010, rand64());
            core_op(CSR_RW, CSR_MSCRATCH, rand64());
            issue_mret();
        join
        apb_xfer(1'b0, CSR_MSCRATCH, '0);
        issue_mret();

        apb_waits = 0;
        for (int i = 0; i < N_RACES; i++) begin
            addr = csr_addr(i + 2);
            data = rand64();
            fork
                apb_xfer(1'b1, addr, data);
                begin
                    @(posedge I_sys_clk);
                    core_op(CSR_RW, addr, rand64());
                end
            join
            apb_xfer(1'b0, addr, '0);
        end
        if (apb_waits == 0) begin
            n_errors++;
            $display("Error at %0t: no APB write had to wait for a core write.", $time);
        end

        repeat (2) @(posedge I_sys_clk);
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 n_checks, n_errors, dut0.u_assert.failures);
        if (n_errors == 0 && dut0.u_assert.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/csr_pkg.sv
rtl/csr_file.sv
rtl/csr_op_unit.sv
rtl/trap_ctrl.sv
rtl/apb_csr_port.sv
rtl/csr_unit_top.sv
bench/csr_unit_assert.sv
bench/tb_csr_unit.sv
